// File: hw/alu_pkg.sv
package alu_pkg;

  localparam int XLEN       = 32;
  localparam int SHAMT_W    = 5;
  localparam int ALUOP_W    = 5;
  localparam int ITER_CNT_W = $clog2(XLEN);

  // last busy cycle of the mul/div loops
  localparam logic [ITER_CNT_W-1:0] ITER_LAST = ITER_CNT_W'(XLEN - 1);

  // shifter select codes
  localparam logic [1:0] SHIFT_SLL = 2'd0;
  localparam logic [1:0] SHIFT_SRL = 2'd1;
  localparam logic [1:0] SHIFT_SRA = 2'd2;

  typedef enum logic [ALUOP_W-1:0] {
    OP_ADD,    // sum
    OP_SUB,    // difference
    OP_AND,    // conjunction
    OP_OR,     // disjunction
    OP_XOR,    // parity
    OP_SLL,    // shl
    OP_SRL,    // lshr
    OP_SRA,    // ashr
    OP_SLT,    // less
    OP_SLTU,   // below
    OP_BEQ,    // equal
    OP_BNE,    // unequal
    OP_BLT,    // less
    OP_BGE,    // notless
    OP_BLTU,   // below
    OP_BGEU,   // notbelow
    OP_MUL,    // product
    OP_MULH,   // high
    OP_MULHSU, // mixed
    OP_MULHU,  // unsignedhigh
    OP_DIV,    // quotient
    OP_DIVU,   // uquotient
    OP_REM,    // remainder
    OP_REMU    // uremainder
  } alu_op_e;

  typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DONE} iter_state_e;

endpackage

// File: hw/alu_shift.sv
`timescale 1ns/100ps

module alu_shift (
  input  logic [1:0]                  shift_op_i,
  input  logic [alu_pkg::XLEN-1:0]    shift_num_i,
  input  logic [alu_pkg::SHAMT_W-1:0] shift_count_i,
  output logic [alu_pkg::XLEN-1:0]    shift_out_o
);
  import alu_pkg::*;

  logic            is_left;
  logic            fill;
  logic [XLEN-1:0] num_rev;
  logic [XLEN-1:0] res_rev;
  logic [XLEN-1:0] stage [SHAMT_W+1];

  assign is_left = (shift_op_i == SHIFT_SLL);
  assign fill    = (shift_op_i == SHIFT_SRA) & shift_num_i[XLEN-1]; // sign fill only for sra

  // left shift by reversing, shifting right and reversing back
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      num_rev[i] = shift_num_i[XLEN-1-i];
    end
  end

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      res_rev[i] = stage[SHAMT_W][XLEN-1-i];
    end
  end

  assign stage[0] = is_left ? num_rev : shift_num_i;

  for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
    assign stage[i+1] = shift_count_i[i] ?
                        {{(1 << i){fill}}, stage[i][XLEN-1:(1 << i)]} : stage[i];
  end

  assign shift_out_o = is_left ? res_rev : stage[SHAMT_W];

endmodule

// File: hw/alu_mul_top.sv
`timescale 1ns/100ps

module alu_mul_top (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       rs1_signed_i,
  input  logic                       rs2_signed_i,
  input  logic [alu_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [alu_pkg::XLEN-1:0]   rs2_data_i,
  input  logic                       mul_valid_i,
  output logic                       mul_ready_o,
  output logic [2*alu_pkg::XLEN-1:0] mul_out_o
);
  import alu_pkg::*;

  iter_state_e           state_q;
  logic [ITER_CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]       mcand_q;  // |rs1|
  logic [2*XLEN-1:0]     prod_q;   // {partial sum, multiplier}
  logic                  neg_q;

  logic            start;
  logic            a_neg, b_neg;
  logic [XLEN-1:0] a_mag, b_mag;
  logic [XLEN:0]   partial;

  assign start = (state_q == ST_IDLE) & mul_valid_i;
  assign a_neg = rs1_signed_i & rs1_data_i[XLEN-1];
  assign b_neg = rs2_signed_i & rs2_data_i[XLEN-1];
  assign a_mag = a_neg ? -rs1_data_i : rs1_data_i;
  assign b_mag = b_neg ? -rs2_data_i : rs2_data_i;

  // add multiplicand into upper half when multiplier lsb set
  assign partial = prod_q[0] ? {1'b0, prod_q[2*XLEN-1:XLEN]} + {1'b0, mcand_q}
                             : {1'b0, prod_q[2*XLEN-1:XLEN]};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (mul_valid_i) state_q <= ST_BUSY;
        end
        ST_BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == ITER_LAST) state_q <= ST_DONE;
        end
        ST_DONE: state_q <= ST_IDLE; // one ready cycle
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mcand_q <= a_mag;
      prod_q  <= {{XLEN{1'b0}}, b_mag};
      neg_q   <= a_neg ^ b_neg;
    end else if (state_q == ST_BUSY) begin
      prod_q <= {partial, prod_q[XLEN-1:1]}; // shift right with carry
    end
  end

  assign mul_ready_o = (state_q == ST_DONE);
  assign mul_out_o   = neg_q ? -prod_q : prod_q; // restore product sign

endmodule

// File: hw/alu_div_top.sv
`timescale 1ns/100ps

module alu_div_top (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     signed_i,
  input  logic [alu_pkg::XLEN-1:0] sr1_data_i,
  input  logic [alu_pkg::XLEN-1:0] sr2_data_i,
  input  logic                     div_valid_i,
  output logic                     div_ready_o,
  output logic [alu_pkg::XLEN-1:0] div_out_o,
  output logic [alu_pkg::XLEN-1:0] rem_out_o
);
  import alu_pkg::*;

  iter_state_e           state_q;
  logic [ITER_CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]       divisor_q;  // |divisor|
  logic [XLEN-1:0]       quo_q;      // dividend bits shift out, quotient bits shift in
  logic [XLEN-1:0]       rem_q;
  logic                  quo_neg_q;
  logic                  rem_neg_q;
  logic                  div_zero_q;

  logic            start;
  logic            a_neg, b_neg;
  logic [XLEN-1:0] a_mag, b_mag;
  logic [XLEN:0]   rem_shift;
  logic [XLEN:0]   trial;

  assign start = (state_q == ST_IDLE) & div_valid_i;
  assign a_neg = signed_i & sr1_data_i[XLEN-1];
  assign b_neg = signed_i & sr2_data_i[XLEN-1];
  assign a_mag = a_neg ? -sr1_data_i : sr1_data_i;
  assign b_mag = b_neg ? -sr2_data_i : sr2_data_i;

  // bring down next dividend bit and try the subtraction
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign trial     = rem_shift - {1'b0, divisor_q};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (div_valid_i) state_q <= ST_BUSY;
        end
        ST_BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == ITER_LAST) state_q <= ST_DONE;
        end
        ST_DONE: state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      divisor_q  <= b_mag;
      quo_q      <= a_mag;
      rem_q      <= '0;
      quo_neg_q  <= a_neg ^ b_neg;
      rem_neg_q  <= a_neg;               // remainder follows dividend
      div_zero_q <= (sr2_data_i == '0);
    end else if (state_q == ST_BUSY) begin
      if (!trial[XLEN]) begin
        rem_q <= trial[XLEN-1:0];        // subtraction fits
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[XLEN-1:0];    // restore
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  assign div_ready_o = (state_q == ST_DONE);

  // a zero divisor forces the quotient to all ones
  // the loop then leaves |dividend| in rem_q and the sign fix restores the dividend
  assign div_out_o = div_zero_q ? '1 : (quo_neg_q ? -quo_q : quo_q);
  assign rem_out_o = rem_neg_q ? -rem_q : rem_q;

  // most negative / -1 runs as |a| / 1 with positive sign and returns a

endmodule

// File: hw/alu_top.sv
`timescale 1ns/100ps

module alu_top (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic [alu_pkg::XLEN-1:0] alu_a_i,
  input  logic [alu_pkg::XLEN-1:0] alu_b_i,
  input  alu_pkg::alu_op_e         alu_op_i,
  output logic [alu_pkg::XLEN-1:0] alu_out_o,
  output logic                     compare_out_o,
  output logic                     alu_stall_req_o
);
  import alu_pkg::*;

  logic is_addsub, is_shift, is_cmp, is_mul, is_mulhi, is_div, is_rem;
  logic is_sub;

  assign is_addsub = alu_op_i inside {OP_ADD, OP_SUB};
  assign is_shift  = alu_op_i inside {OP_SLL, OP_SRL, OP_SRA};
  assign is_cmp    = alu_op_i inside {OP_SLT, OP_SLTU, OP_BEQ, OP_BNE,
                                      OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  assign is_mul    = alu_op_i inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign is_mulhi  = alu_op_i inside {OP_MULH, OP_MULHSU, OP_MULHU};
  assign is_div    = alu_op_i inside {OP_DIV, OP_DIVU};
  assign is_rem    = alu_op_i inside {OP_REM, OP_REMU};
  assign is_sub    = (alu_op_i == OP_SUB) | is_cmp; // compares subtract too

  // shared 33-bit adder for a + b or a + ~b + 1
  logic [XLEN:0] add_a, add_b, add_sum;
  logic          flag_z, flag_of, flag_sf, flag_cf;
  logic          lt_s, lt_u, cmp_res;

  assign add_a   = {alu_a_i[XLEN-1], alu_a_i};
  assign add_b   = {alu_b_i[XLEN-1], alu_b_i} ^ {(XLEN+1){is_sub}};
  assign add_sum = add_a + add_b + {{XLEN{1'b0}}, is_sub};

  assign flag_z  = (add_sum == '0);
  assign flag_of = add_sum[XLEN] ^ add_sum[XLEN-1];
  assign flag_sf = add_sum[XLEN-1];
  assign flag_cf = is_sub ^ (add_a[XLEN] ^ add_b[XLEN] ^ add_sum[XLEN]); // borrow on sub
  assign lt_s    = flag_sf ^ flag_of;
  assign lt_u    = flag_cf;

  assign cmp_res = ((alu_op_i inside {OP_SLT, OP_BLT}) & lt_s) |
                   ((alu_op_i inside {OP_SLTU, OP_BLTU}) & lt_u) |
                   ((alu_op_i == OP_BGE) & ~lt_s) |
                   ((alu_op_i == OP_BGEU) & ~lt_u) |
                   ((alu_op_i == OP_BEQ) & flag_z) |
                   ((alu_op_i == OP_BNE) & ~flag_z);

  logic [1:0]      shift_op;
  logic [XLEN-1:0] shift_res;

  assign shift_op = (alu_op_i == OP_SRA) ? SHIFT_SRA :
                    (alu_op_i == OP_SRL) ? SHIFT_SRL : SHIFT_SLL;

  alu_shift u_alu_shift (
    .shift_op_i   (shift_op),
    .shift_num_i  (alu_a_i),
    .shift_count_i(alu_b_i[SHAMT_W-1:0]),  // low five bits only
    .shift_out_o  (shift_res)
  );

  // request to the iterative units held while the op waits for ready
  logic              mul_ready, mul_stall;
  logic [2*XLEN-1:0] mul_res;
  logic              div_ready, div_stall;
  logic [XLEN-1:0]   div_res, rem_res;

  assign mul_stall = is_mul & ~mul_ready;
  assign div_stall = (is_div | is_rem) & ~div_ready;

  alu_mul_top u_alu_mul_top (
    .clk         (clk),
    .rst_i       (rst_i),
    .rs1_signed_i(alu_op_i inside {OP_MUL, OP_MULH, OP_MULHSU}),
    .rs2_signed_i(alu_op_i inside {OP_MUL, OP_MULH}),
    .rs1_data_i  (alu_a_i),
    .rs2_data_i  (alu_b_i),
    .mul_valid_i (mul_stall),
    .mul_ready_o (mul_ready),
    .mul_out_o   (mul_res)
  );

  alu_div_top u_alu_div_top (
    .clk        (clk),
    .rst_i      (rst_i),
    .signed_i   (alu_op_i inside {OP_DIV, OP_REM}),
    .sr1_data_i (alu_a_i),
    .sr2_data_i (alu_b_i),
    .div_valid_i(div_stall),
    .div_ready_o(div_ready),
    .div_out_o  (div_res),
    .rem_out_o  (rem_res)
  );

  logic [XLEN-1:0] alu_res;

  assign alu_res = ({XLEN{is_addsub}} & add_sum[XLEN-1:0]) |
                   ({XLEN{alu_op_i == OP_AND}} & (alu_a_i & alu_b_i)) |
                   ({XLEN{alu_op_i == OP_OR}} & (alu_a_i | alu_b_i)) |
                   ({XLEN{alu_op_i == OP_XOR}} & (alu_a_i ^ alu_b_i)) |
                   ({XLEN{is_shift}} & shift_res) |
                   ({XLEN{alu_op_i == OP_MUL}} & mul_res[XLEN-1:0]) |
                   ({XLEN{is_mulhi}} & mul_res[2*XLEN-1:XLEN]) |
                   ({XLEN{is_div}} & div_res) |
                   ({XLEN{is_rem}} & rem_res);

  assign alu_out_o       = is_cmp ? {{(XLEN-1){1'b0}}, cmp_res} : alu_res;
  assign compare_out_o   = cmp_res;   // zero for non-compare ops
  assign alu_stall_req_o = mul_stall | div_stall;

endmodule

// File: include/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// branch/compare outcome that is 0 for every other op
function automatic logic ref_compare(
  input alu_pkg::alu_op_e         op,
  input logic [alu_pkg::XLEN-1:0] a,
  input logic [alu_pkg::XLEN-1:0] b
);
  logic lt_s;
  logic lt_u;
  lt_s = $signed(a) < $signed(b);
  lt_u = a < b;
  case (op)
    alu_pkg::OP_SLT, alu_pkg::OP_BLT:   return lt_s;
    alu_pkg::OP_SLTU, alu_pkg::OP_BLTU: return lt_u;
    alu_pkg::OP_BGE:                    return !lt_s;
    alu_pkg::OP_BGEU:                   return !lt_u;
    alu_pkg::OP_BEQ:                    return a == b;
    alu_pkg::OP_BNE:                    return a != b;
    default:                            return 1'b0;
  endcase
endfunction

function automatic logic [alu_pkg::XLEN-1:0] ref_alu_result(
  input alu_pkg::alu_op_e         op,
  input logic [alu_pkg::XLEN-1:0] a,
  input logic [alu_pkg::XLEN-1:0] b
);
  logic [2*alu_pkg::XLEN-1:0]      prod_ss;
  logic [2*alu_pkg::XLEN-1:0]      prod_su;
  logic [2*alu_pkg::XLEN-1:0]      prod_uu;
  logic signed [alu_pkg::XLEN-1:0] sa;
  logic signed [alu_pkg::XLEN-1:0] sb;
  logic                            ovf;
  sa      = a;
  sb      = b;
  prod_ss = $signed(a) * $signed(b);
  prod_su = $signed(a) * $signed({1'b0, b});
  prod_uu = a * b;
  ovf     = (a == {1'b1, {(alu_pkg::XLEN-1){1'b0}}}) && (b == '1); // min / -1
  case (op)
    alu_pkg::OP_ADD:    return a + b;
    alu_pkg::OP_SUB:    return a - b;
    alu_pkg::OP_AND:    return a & b;
    alu_pkg::OP_OR:     return a | b;
    alu_pkg::OP_XOR:    return a ^ b;
    alu_pkg::OP_SLL:    return a << b[alu_pkg::SHAMT_W-1:0];
    alu_pkg::OP_SRL:    return a >> b[alu_pkg::SHAMT_W-1:0];
    alu_pkg::OP_SRA:    return $signed(a) >>> b[alu_pkg::SHAMT_W-1:0];
    alu_pkg::OP_MUL:    return prod_ss[alu_pkg::XLEN-1:0];
    alu_pkg::OP_MULH:   return prod_ss[2*alu_pkg::XLEN-1:alu_pkg::XLEN];
    alu_pkg::OP_MULHSU: return prod_su[2*alu_pkg::XLEN-1:alu_pkg::XLEN];
    alu_pkg::OP_MULHU:  return prod_uu[2*alu_pkg::XLEN-1:alu_pkg::XLEN];
    alu_pkg::OP_DIV: begin
      if (b == '0) return '1;
      if (ovf) return a;
      return sa / sb;  // truncates toward zero
    end
    alu_pkg::OP_DIVU:   return (b == '0) ? '1 : a / b;
    alu_pkg::OP_REM: begin
      if (b == '0) return a;
      if (ovf) return '0;
      return sa % sb;  // sign of the dividend
    end
    alu_pkg::OP_REMU:   return (b == '0) ? a : a % b;
    default:            return {{(alu_pkg::XLEN-1){1'b0}}, ref_compare(op, a, b)};
  endcase
endfunction

`endif

// File: dv/tb_alu_top.sv
`timescale 1ns/100ps

module tb_alu_top;
  import alu_pkg::*;

  `include "alu_ref_model.svh"

  localparam int STALL_TIMEOUT = 100;

  logic            clk;
  logic            rst_i;
  logic [XLEN-1:0] alu_a, alu_b, alu_out;
  alu_op_e         alu_op;
  logic            compare_out, stall_req;
  int unsigned     num_checks;

  alu_op_e comb_ops [8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
  alu_op_e cmp_ops  [8] = '{OP_SLT, OP_SLTU, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  alu_op_e mul_ops  [4] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  alu_op_e div_ops  [4] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  logic [XLEN-1:0] corner_vals [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  alu_top dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .alu_a_i        (alu_a),
    .alu_b_i        (alu_b),
    .alu_op_i       (alu_op),
    .alu_out_o      (alu_out),
    .compare_out_o  (compare_out),
    .alu_stall_req_o(stall_req)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [XLEN-1:0] zero_extend(input logic bit_in);
    return {{(XLEN-1){1'b0}}, bit_in};
  endfunction

  // one in eight from the corner set
  function automatic logic [XLEN-1:0] rand_operand();
    if ($urandom_range(7) == 0) return corner_vals[$urandom_range(4)];
    return $urandom();
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] got, exp);
    num_checks++;
    if (got !== exp)
      fail_run($sformatf("FAILED at %0t: %s got %08h expected %08h", $time, what, got, exp));
  endtask

  task automatic drive_op(input alu_op_e o, input logic [XLEN-1:0] x, y);
    @(posedge clk);
    alu_op <= o;
    alu_a  <= x;
    alu_b  <= y;
  endtask

  task automatic run_comb(input alu_op_e o, input logic [XLEN-1:0] x, y);
    string tag;
    drive_op(o, x, y);
    @(negedge clk);  // outputs settled
    tag = $sformatf("%s a=%08h b=%08h", o.name(), x, y);
    check_value({tag, " stall"}, zero_extend(stall_req), '0);
    check_value({tag, " result"}, alu_out, ref_alu_result(o, x, y));
    check_value({tag, " compare"}, zero_extend(compare_out), zero_extend(ref_compare(o, x, y)));
  endtask

  task automatic run_multi(input alu_op_e o, input logic [XLEN-1:0] x, y);
    string tag;
    int    cycles;
    drive_op(o, x, y);
    @(negedge clk);
    tag = $sformatf("%s a=%08h b=%08h", o.name(), x, y);
    check_value({tag, " stall raised"}, zero_extend(stall_req), 32'd1);
    cycles = 0;
    while (stall_req) begin
      @(negedge clk);
      cycles++;
      if (cycles > STALL_TIMEOUT)
        fail_run($sformatf("%s: stall never released within %0d cycles", tag, STALL_TIMEOUT));
    end
    check_value({tag, " result"}, alu_out, ref_alu_result(o, x, y)); // ready cycle
    check_value({tag, " compare"}, zero_extend(compare_out), '0);
  endtask

  initial begin
    logic [XLEN-1:0] x, y;
    rst_i      = 1'b1;
    alu_op     = OP_ADD;
    alu_a      = '0;
    alu_b      = '0;
    num_checks = 0;
    void'($urandom(32'he1405346));
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_value("OP_ADD stall after reset", zero_extend(stall_req), '0);

    repeat (400) run_comb(comb_ops[$urandom_range(7)], rand_operand(), rand_operand());

    run_comb(OP_BLT, 32'h8000_0000, 32'h7fff_ffff);  // signed and unsigned disagree
    run_comb(OP_BLTU, 32'h8000_0000, 32'h7fff_ffff);
    for (int i = 0; i < 300; i++) begin
      x = rand_operand();
      y = ($urandom_range(3) == 0) ? x : rand_operand();  // equal operands now and then
      run_comb(cmp_ops[$urandom_range(7)], x, y);
    end

    repeat (150) run_multi(mul_ops[$urandom_range(3)], rand_operand(), rand_operand());

    run_multi(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_multi(OP_REM, 32'h8000_0000, 32'hffff_ffff);
    foreach (div_ops[i]) run_multi(div_ops[i], rand_operand(), '0);
    for (int i = 0; i < 150; i++) begin
      x = rand_operand();
      y = ($urandom_range(7) == 0) ? '0 : rand_operand();
      run_multi(div_ops[$urandom_range(3)], x, y);
    end

    // multi-cycle, combinational, multi-cycle with no idle cycle between
    repeat (20) begin
      run_multi($urandom_range(1) ? mul_ops[$urandom_range(3)] : div_ops[$urandom_range(3)],
                rand_operand(), rand_operand());
      run_comb(comb_ops[$urandom_range(7)], rand_operand(), rand_operand());
      run_multi($urandom_range(1) ? mul_ops[$urandom_range(3)] : div_ops[$urandom_range(3)],
                rand_operand(), rand_operand());
    end

    $display("%0d checks done", num_checks);
    $display("Test passed");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
hw/alu_pkg.sv
hw/alu_shift.sv
hw/alu_mul_top.sv
hw/alu_div_top.sv
hw/alu_top.sv
dv/tb_alu_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_alu_top \
  -Mdir obj_dir -o sim_alu

# the simulator's status is not used; the grep below decides
out=$(./obj_dir/sim_alu 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi
